// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_trdb
FILELIST   := all.f
COMMON     := --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --assert -Mdir obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
+incdir+.
trdb_pkg.sv
trdb_branch_map.sv
trdb_decode.sv
trdb_execute.sv
trdb_result.sv
trdb_top.sv
trdb_sva.sv
tb_trdb.sv

// File: tb_trdb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the trace encoder top
// lfsr program walk, reference model, packet compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module tb_trdb import trdb_pkg::*; ();

    localparam int          TIMEOUT  = 200;
    localparam logic [31:0] SEED     = 32'hb17387ec;
    localparam logic [31:0] TAPS     = 32'h8020_0003;
    // taken outcomes of the directed branch runs
    localparam logic [7:0]  PATTERN  = 8'b1001_1101;
    localparam int          K_PLAIN  = 0;
    localparam int          K_BRANCH = 1;
    localparam int          K_JALR   = 2;
    localparam int          K_TRAP   = 3;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  trace_enable_i;
    logic                  inst_valid_i;
    trdb_inst_t            inst_i;
    logic [`TRDB_XLEN-1:0] epc_i;
    logic                  inst_ready_o;
    logic                  packet_valid_o;
    trdb_pkt_t             packet_o;
    logic                  packet_ready_i;

    logic [31:0]           lfsr_q;
    logic [`TRDB_XLEN-1:0] pc;
    // random encapsulator stalls on/off
    logic                  bp_on;
    // reference model state
    trdb_inst_t            m_held;
    logic [`TRDB_XLEN-1:0] m_epc;
    logic                  m_valid;
    logic                  m_first;
    logic                  m_armed;
    logic [7:0]            m_map;
    logic [3:0]            m_count;
    trdb_pkt_t             exp_q[$];
    int                    seen;

    trdb_top trdb_top_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .trace_enable_i (trace_enable_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .epc_i          (epc_i),
        .inst_ready_o   (inst_ready_o),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o),
        .packet_ready_i (packet_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic compare_values(input string what, input logic [127:0] got,
                                  input logic [127:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERROR at %0t: %s got %0h, expected %0h",
                                $time, what, got, want));
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? TAPS : 32'd0);
        end
        return v;
    endfunction

    function automatic void reset_model();
        m_valid = 1'b0;
        m_armed = 1'b1;
        m_map   = '0;
        m_count = '0;
    endfunction

    // packet rules for the held instruction once its successor is known
    function automatic logic predict_packet(input trdb_inst_t cur, input logic [31:0] epc,
                                            input logic first, input logic [31:0] next,
                                            output trdb_pkt_t pkt);
        logic emit;
        pkt  = '0;
        emit = 1'b1;
        if (first) begin
            pkt.format        = F_SYNC;
            pkt.subformat     = SF_START;
            pkt.length        = 4'd5;
            pkt.payload[1:0]  = cur.priv;
            pkt.payload[33:2] = cur.iaddr;
        end else if (cur.trap) begin
            pkt.format         = F_SYNC;
            pkt.subformat      = SF_TRAP;
            pkt.length         = 4'd9;
            pkt.payload[1:0]   = cur.priv;
            pkt.payload[2]     = cur.interrupt;
            pkt.payload[7:3]   = cur.cause;
            pkt.payload[39:8]  = epc;
            pkt.payload[71:40] = cur.iaddr;
        end else if (cur.inst[6:0] == 7'b1100111 && m_count != 4'd0) begin
            pkt.format         = F_BRANCH_FULL;
            pkt.length         = 4'd6;
            pkt.payload[3:0]   = m_count;
            pkt.payload[11:4]  = m_map;
            pkt.payload[43:12] = next;
        end else if (cur.inst[6:0] == 7'b1100111) begin
            pkt.format        = F_ADDR_ONLY;
            pkt.length        = 4'd4;
            pkt.payload[31:0] = next;
        end else if (cur.inst[6:0] == 7'b1100011) begin
            // 1 marks a fall-through branch
            m_map[m_count[2:0]] = (next == cur.iaddr + 32'd4);
            m_count             = m_count + 4'd1;
            emit                = (m_count == 4'd8);
            pkt.format          = F_BRANCH_FULL;
            pkt.length          = 4'd2;
            pkt.payload[3:0]    = m_count;
            pkt.payload[11:4]   = m_map;
        end else begin
            emit = 1'b0;
        end
        // any packet empties the map
        if (emit) begin
            m_map   = '0;
            m_count = '0;
        end
        return emit;
    endfunction

    // beat taken by the dut, beats while disabled are dropped
    function automatic void accept_beat(input trdb_inst_t beat, input logic [31:0] epc);
        trdb_pkt_t pkt;
        if (trace_enable_i) begin
            if (m_valid) begin
                if (predict_packet(m_held, m_epc, m_first, beat.iaddr, pkt)) begin
                    exp_q.push_back(pkt);
                end
            end
            m_held  = beat;
            m_epc   = epc;
            m_first = m_armed;
            m_armed = 1'b0;
            m_valid = 1'b1;
        end
    endfunction

    // falling edge, then the encapsulator ready for this cycle
    task automatic next_cycle();
        @(negedge clk_i);
        packet_ready_i = bp_on ? (lfsr_bits(2) != 32'd0) : 1'b1;
    endtask

    task automatic idle_cycle();
        next_cycle();
        inst_valid_i = 1'b0;
    endtask

    task automatic send_beat(input trdb_inst_t beat, input logic [`TRDB_XLEN-1:0] epc);
        int waited;
        waited = 0;
        next_cycle();
        inst_valid_i = 1'b1;
        inst_i       = beat;
        epc_i        = epc;
        // sampled a nanosecond before the rising edge
        #1;
        while (!inst_ready_o) begin
            if (waited == TIMEOUT) begin
                abort_run("core beat was not accepted before the timeout");
            end
            waited++;
            next_cycle();
            #1;
        end
        accept_beat(beat, epc);
    endtask

    // one step of the program walk
    task automatic run_inst(input int kind, input logic taken);
        trdb_inst_t            beat;
        logic [`TRDB_XLEN-1:0] epc;
        logic [`TRDB_XLEN-1:0] target;
        beat       = '0;
        beat.iaddr = pc;
        beat.inst  = 32'h0000_0013;
        beat.priv  = 2'(lfsr_bits(2));
        // junk epc, only trap beats carry a real one
        epc        = ~pc;
        target     = pc + 32'd4;
        if (kind == K_BRANCH) begin
            // beq x1, x2, +8
            beat.inst = 32'h0020_8463;
            if (taken) begin
                target = pc + 32'd8;
            end
        end else if (kind == K_JALR) begin
            beat.inst = 32'h0000_8067;
            target    = lfsr_bits(30) << 2;
        end else if (kind == K_TRAP) begin
            // first handler instruction, interrupted pc in epc
            beat.trap      = 1'b1;
            beat.interrupt = (lfsr_bits(1) != 32'd0);
            beat.cause     = 5'(lfsr_bits(5));
            beat.iaddr     = 32'h0000_0100 + {25'd0, beat.cause, 2'b00};
            epc            = pc;
            target         = beat.iaddr + 32'd4;
        end
        pc = target;
        send_beat(beat, epc);
    endtask

    task automatic set_enable(input logic en);
        next_cycle();
        inst_valid_i   = 1'b0;
        trace_enable_i = en;
        if (!en) begin
            reset_model();
        end
    endtask

    // pops one expected packet per output handshake
    initial begin : compare_proc
        trdb_pkt_t want;
        forever begin
            @(negedge clk_i);
            #1;
            if (packet_valid_o && packet_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("DUT emitted a packet that the model did not expect");
                end
                want = exp_q.pop_front();
                compare_values($sformatf("packet %0d", seen), 128'(packet_o), 128'(want));
                seen++;
            end
        end
    end

    initial begin : main
        int          i;
        int          waited;
        logic [31:0] sel;
        lfsr_q         = SEED;
        pc             = 32'h0000_1000;
        bp_on          = 1'b0;
        seen           = 0;
        rst_ni         = 1'b0;
        trace_enable_i = 1'b0;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        epc_i          = '0;
        packet_ready_i = 1'b1;
        reset_model();
        repeat (8) @(posedge clk_i);
        next_cycle();
        rst_ni = 1'b1;

        set_enable(1'b1);
        // decode empty and no packet out of reset
        #1;
        compare_values("inst_ready_o after reset", 128'(inst_ready_o), 128'(1'b1));
        compare_values("packet_valid_o after reset", 128'(packet_valid_o), 128'(1'b0));
        // start sync on the first beat
        run_inst(K_PLAIN, 1'b0);
        run_inst(K_PLAIN, 1'b0);
        // full branch map
        for (i = 0; i < 8; i++) begin
            run_inst(K_BRANCH, PATTERN[i[2:0]]);
        end
        run_inst(K_PLAIN, 1'b0);
        // jalr with three pending branches, then with none
        for (i = 0; i < 3; i++) begin
            run_inst(K_BRANCH, PATTERN[i[2:0]]);
        end
        run_inst(K_JALR, 1'b0);
        run_inst(K_JALR, 1'b0);
        run_inst(K_PLAIN, 1'b0);
        // trap drops two pending branches
        run_inst(K_BRANCH, 1'b0);
        run_inst(K_BRANCH, 1'b1);
        run_inst(K_TRAP, 1'b0);
        run_inst(K_PLAIN, 1'b0);
        // map restarts after the trap
        run_inst(K_BRANCH, 1'b1);
        run_inst(K_JALR, 1'b0);
        // tracing stops with a branch pending and a jalr held
        run_inst(K_BRANCH, 1'b0);
        run_inst(K_JALR, 1'b0);
        // disable, beats swallowed, then a fresh start
        set_enable(1'b0);
        run_inst(K_BRANCH, 1'b0);
        run_inst(K_PLAIN, 1'b0);
        set_enable(1'b1);
        run_inst(K_PLAIN, 1'b0);
        run_inst(K_PLAIN, 1'b0);

        // random walk under encapsulator stalls
        bp_on = 1'b1;
        for (i = 0; i < 400; i++) begin
            if (lfsr_bits(2) == 32'd0) begin
                idle_cycle();
            end
            sel = lfsr_bits(3);
            if (sel < 32'd4) begin
                run_inst(K_PLAIN, 1'b0);
            end else if (sel < 32'd6) begin
                run_inst(K_BRANCH, lfsr_bits(1) != 32'd0);
            end else if (sel == 32'd6) begin
                run_inst(K_JALR, 1'b0);
            end else begin
                run_inst(K_TRAP, 1'b0);
            end
        end

        // drain the output
        idle_cycle();
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == TIMEOUT) begin
                abort_run("expected packets did not appear before the timeout");
            end
            waited++;
            idle_cycle();
        end
        repeat (10) idle_cycle();
        // nothing left behind in the output register
        compare_values("packet_valid_o after drain", 128'(packet_valid_o), 128'(1'b0));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: trdb_branch_map.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch map, outcome bits of pending conditional branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module trdb_branch_map (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      push_i,
    input  logic                      not_taken_i,
    input  logic                      flush_i,
    output logic [`TRDB_BMAP_LEN-1:0] map_o,
    output logic [`TRDB_BCNT_LEN-1:0] count_o
);

    // bit position inside the map
    localparam int unsigned IDX_W = $clog2(`TRDB_BMAP_LEN);

    logic [`TRDB_BMAP_LEN-1:0] map_q;
    logic [`TRDB_BCNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // also covers the push that fills the map
            map_q   <= '0;
            count_q <= '0;
        end else if (push_i) begin
            // oldest branch in bit 0, 1 = not taken
            map_q[count_q[IDX_W-1:0]] <= not_taken_i;
            count_q                   <= count_q + 1'b1;
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;

endmodule

// File: trdb_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace encoder build constants
// address, trap field, branch map and packet widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRDB_CFG_SVH
`define TRDB_CFG_SVH

// address and instruction width
`define TRDB_XLEN 32
// trap cause as delivered by the core
`define TRDB_CAUSE_LEN 5
// machine, supervisor, user
`define TRDB_PRIV_LEN 2

// branches collected before a full map packet
`define TRDB_BMAP_LEN 8
// must hold the value TRDB_BMAP_LEN
`define TRDB_BCNT_LEN 4

// packet body handed to the encapsulator
`define TRDB_PAYLOAD_LEN 96
// packet length in bytes
`define TRDB_PLEN_LEN 4

`endif

// File: trdb_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage of the trace encoder
// holds this-cycle instruction, resolves it against the next beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module trdb_decode import trdb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  trace_enable_i,
    input  logic                  inst_valid_i,
    input  trdb_inst_t            inst_i,
    input  logic [`TRDB_XLEN-1:0] epc_i,
    output logic                  inst_ready_o,
    output logic                  dec_valid_o,
    output trdb_dec_t             dec_o,
    input  logic                  dec_ready_i
);

    // rv32 major opcodes of interest
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    // no compressed instructions
    localparam logic [`TRDB_XLEN-1:0] INST_BYTES = `TRDB_XLEN'(4);

    logic                  hold_valid_q;
    logic                  hold_first_q;
    logic                  first_armed_q;
    trdb_inst_t            hold_q;
    logic [`TRDB_XLEN-1:0] hold_epc_q;
    logic                  accept;
    logic [6:0]            opcode;
    logic [`TRDB_XLEN-1:0] seq_iaddr;

    // empty slot, or held instruction leaves in this cycle
    // beats are swallowed while tracing is off
    assign inst_ready_o = !trace_enable_i || !hold_valid_q || dec_ready_i;
    assign accept       = inst_valid_i && inst_ready_o;
    // a waiting beat resolves the held instruction
    assign dec_valid_o  = trace_enable_i && hold_valid_q && inst_valid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_valid_q  <= 1'b0;
            hold_first_q  <= 1'b0;
            first_armed_q <= 1'b1;
        end else if (!trace_enable_i) begin
            // drop held instruction, next one restarts the trace
            hold_valid_q  <= 1'b0;
            first_armed_q <= 1'b1;
        end else if (accept) begin
            hold_valid_q  <= 1'b1;
            hold_first_q  <= first_armed_q;
            first_armed_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_q     <= inst_i;
            hold_epc_q <= epc_i;
        end
    end

    assign opcode    = hold_q.inst[6:0];
    assign seq_iaddr = hold_q.iaddr + INST_BYTES;

    always_comb begin
        dec_o.iaddr       = hold_q.iaddr;
        dec_o.epc         = hold_epc_q;
        dec_o.priv        = hold_q.priv;
        dec_o.cause       = hold_q.cause;
        dec_o.interrupt   = hold_q.interrupt;
        dec_o.is_branch   = (opcode == OPC_BRANCH);
        dec_o.is_updiscon = (opcode == OPC_JALR);
        dec_o.trap        = hold_q.trap;
        dec_o.first       = hold_first_q;
        // anything but fall-through counts as taken
        dec_o.taken       = (inst_i.iaddr != seq_iaddr);
        dec_o.next_iaddr  = inst_i.iaddr;
    end

endmodule

// File: trdb_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet decision for the trace encoder
// priority rules, branch map control, field selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module trdb_execute import trdb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      trace_enable_i,
    input  logic      dec_valid_i,
    input  trdb_dec_t dec_i,
    output logic      dec_ready_o,
    output logic      pkt_valid_o,
    output trdb_pkt_t pkt_o,
    input  logic      pkt_ready_i
);

    localparam int unsigned IDX_W = $clog2(`TRDB_BMAP_LEN);
    // count before the push that fills the map
    localparam logic [`TRDB_BCNT_LEN-1:0] LAST_SLOT = `TRDB_BCNT_LEN'(`TRDB_BMAP_LEN - 1);

    logic                      accept;
    logic                      emit;
    logic                      push;
    logic                      flush;
    logic [`TRDB_BMAP_LEN-1:0] map;
    logic [`TRDB_BCNT_LEN-1:0] count;
    logic [`TRDB_BMAP_LEN-1:0] map_next;
    logic [`TRDB_BCNT_LEN-1:0] count_next;
    logic [`TRDB_XLEN-1:0]     addr;

    // one decision per instruction, result stage sets the pace
    assign dec_ready_o = pkt_ready_i;
    assign accept      = dec_valid_i && dec_ready_o;
    assign pkt_valid_o = dec_valid_i && emit;

    trdb_branch_map i_branch_map (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (accept && push),
        .not_taken_i (!dec_i.taken),
        // tracing off empties the map without a packet
        .flush_i     ((accept && flush) || !trace_enable_i),
        .map_o       (map),
        .count_o     (count)
    );

    // map as it looks with this branch included
    always_comb begin
        map_next                   = map;
        map_next[count[IDX_W-1:0]] = !dec_i.taken;
        count_next                 = count + 1'b1;
    end

    always_comb begin
        emit          = 1'b0;
        push          = 1'b0;
        flush         = 1'b0;
        addr          = dec_i.iaddr;
        pkt_o.format    = F_ADDR_ONLY;
        pkt_o.subformat = SF_START;
        if (dec_i.first) begin
            // start of trace
            emit            = 1'b1;
            flush           = 1'b1;
            pkt_o.format    = F_SYNC;
            pkt_o.subformat = SF_START;
        end else if (dec_i.trap) begin
            // handler entry, pending branches are dropped
            emit            = 1'b1;
            flush           = 1'b1;
            pkt_o.format    = F_SYNC;
            pkt_o.subformat = SF_TRAP;
        end else if (dec_i.is_updiscon) begin
            emit         = 1'b1;
            flush        = 1'b1;
            addr         = dec_i.next_iaddr;
            pkt_o.format = (count != '0) ? F_BRANCH_FULL : F_ADDR_ONLY;
        end else if (dec_i.is_branch) begin
            push = 1'b1;
            if (count == LAST_SLOT) begin
                emit         = 1'b1;
                flush        = 1'b1;
                pkt_o.format = F_BRANCH_FULL;
            end
        end
        // length is set by result
        pkt_o.length  = '0;
        // field bus for result: priv, interrupt, cause, epc, addr, map, count
        pkt_o.payload = `TRDB_PAYLOAD_LEN'({
            push ? count_next : count,
            push ? map_next : map,
            addr,
            dec_i.epc,
            dec_i.cause,
            dec_i.interrupt,
            dec_i.priv
        });
    end

endmodule

// File: trdb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace encoder types
// packet formats, core beat, decoded instruction and packet structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "trdb_cfg.svh"

package trdb_pkg;

    // e-trace packet formats, format 0 is not produced
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    // subformats of the sync format
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_sub_e;

    // one retired instruction from the core
    typedef struct packed {
        logic [`TRDB_XLEN-1:0]      iaddr;
        logic [`TRDB_XLEN-1:0]      inst;
        // first instruction of a trap handler
        logic                       trap;
        logic                       interrupt;
        logic [`TRDB_CAUSE_LEN-1:0] cause;
        logic [`TRDB_PRIV_LEN-1:0]  priv;
    } trdb_inst_t;

    // this-cycle instruction, resolved by the next one
    typedef struct packed {
        logic [`TRDB_XLEN-1:0]      iaddr;
        logic [`TRDB_XLEN-1:0]      epc;
        logic [`TRDB_PRIV_LEN-1:0]  priv;
        logic [`TRDB_CAUSE_LEN-1:0] cause;
        logic                       interrupt;
        logic                       is_branch;
        // jalr, target not inferable from the program
        logic                       is_updiscon;
        logic                       trap;
        // first traced instruction after enable
        logic                       first;
        logic                       taken;
        logic [`TRDB_XLEN-1:0]      next_iaddr;
    } trdb_dec_t;

    // packet towards the encapsulator
    typedef struct packed {
        trdb_format_e                format;
        logic [1:0]                  subformat;
        logic [`TRDB_PLEN_LEN-1:0]   length;
        logic [`TRDB_PAYLOAD_LEN-1:0] payload;
    } trdb_pkt_t;

endpackage

// File: trdb_result.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet output stage, payload packing and length
// registered valid/ready towards the encapsulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module trdb_result import trdb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      pkt_valid_i,
    input  trdb_pkt_t pkt_i,
    output logic      pkt_ready_o,
    output logic      packet_valid_o,
    output trdb_pkt_t packet_o,
    input  logic      packet_ready_i
);

    // field positions on the bus from execute
    localparam int unsigned OFS_INT   = `TRDB_PRIV_LEN;
    localparam int unsigned OFS_CAUSE = OFS_INT + 1;
    localparam int unsigned OFS_EPC   = OFS_CAUSE + `TRDB_CAUSE_LEN;
    localparam int unsigned OFS_ADDR  = OFS_EPC + `TRDB_XLEN;
    localparam int unsigned OFS_MAP   = OFS_ADDR + `TRDB_XLEN;
    localparam int unsigned OFS_CNT   = OFS_MAP + `TRDB_BMAP_LEN;
    // a full map travels without address
    localparam logic [`TRDB_BCNT_LEN-1:0] BCNT_FULL = `TRDB_BCNT_LEN'(`TRDB_BMAP_LEN);

    logic                       valid_q;
    trdb_pkt_t                  packet_q;
    trdb_pkt_t                  packed_pkt;
    logic [`TRDB_PRIV_LEN-1:0]  priv;
    logic                       intr;
    logic [`TRDB_CAUSE_LEN-1:0] cause;
    logic [`TRDB_XLEN-1:0]      epc;
    logic [`TRDB_XLEN-1:0]      addr;
    logic [`TRDB_BMAP_LEN-1:0]  bmap;
    logic [`TRDB_BCNT_LEN-1:0]  bcnt;

    assign priv  = pkt_i.payload[`TRDB_PRIV_LEN-1:0];
    assign intr  = pkt_i.payload[OFS_INT];
    assign cause = pkt_i.payload[OFS_CAUSE +: `TRDB_CAUSE_LEN];
    assign epc   = pkt_i.payload[OFS_EPC +: `TRDB_XLEN];
    assign addr  = pkt_i.payload[OFS_ADDR +: `TRDB_XLEN];
    assign bmap  = pkt_i.payload[OFS_MAP +: `TRDB_BMAP_LEN];
    assign bcnt  = pkt_i.payload[OFS_CNT +: `TRDB_BCNT_LEN];

    // lsb first, unused bits zero, length rounded up to bytes
    always_comb begin
        packed_pkt         = pkt_i;
        packed_pkt.payload = '0;
        packed_pkt.length  = '0;
        case (pkt_i.format)
            F_SYNC: begin
                if (pkt_i.subformat == SF_START) begin
                    packed_pkt.payload = `TRDB_PAYLOAD_LEN'({addr, priv});
                    packed_pkt.length  = `TRDB_PLEN_LEN'(5);
                end else begin
                    packed_pkt.payload = `TRDB_PAYLOAD_LEN'({addr, epc, cause, intr, priv});
                    packed_pkt.length  = `TRDB_PLEN_LEN'(9);
                end
            end
            F_BRANCH_FULL: begin
                if (bcnt == BCNT_FULL) begin
                    packed_pkt.payload = `TRDB_PAYLOAD_LEN'({bmap, bcnt});
                    packed_pkt.length  = `TRDB_PLEN_LEN'(2);
                end else begin
                    // jalr with pending branches
                    packed_pkt.payload = `TRDB_PAYLOAD_LEN'({addr, bmap, bcnt});
                    packed_pkt.length  = `TRDB_PLEN_LEN'(6);
                end
            end
            F_ADDR_ONLY: begin
                packed_pkt.payload = `TRDB_PAYLOAD_LEN'(addr);
                packed_pkt.length  = `TRDB_PLEN_LEN'(4);
            end
            default: begin
                packed_pkt.length = '0;
            end
        endcase
    end

    // empty, or current packet leaves this cycle
    assign pkt_ready_o = !valid_q || packet_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (pkt_ready_o) begin
            valid_q <= pkt_valid_i;
        end
    end

    // held stable while the encapsulator stalls
    always_ff @(posedge clk_i) begin
        if (pkt_valid_i && pkt_ready_o) begin
            packet_q <= packed_pkt;
        end
    end

    assign packet_valid_o = valid_q;
    assign packet_o       = packet_q;

endmodule

// File: trdb_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output handshake and packet length checks, bound to the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module trdb_sva import trdb_pkg::*; (
    input logic      clk_i,
    input logic      rst_ni,
    input logic      packet_valid_i,
    input trdb_pkt_t packet_i,
    input logic      packet_ready_i
);

    logic [`TRDB_PLEN_LEN-1:0] want_len;

    // byte length implied by format, subformat and count
    always_comb begin
        case (packet_i.format)
            F_SYNC:        want_len = (packet_i.subformat == SF_START) ? 4'd5 : 4'd9;
            F_ADDR_ONLY:   want_len = 4'd4;
            F_BRANCH_FULL: want_len = (packet_i.payload[3:0] == 4'd8) ? 4'd2 : 4'd6;
            default:       want_len = '0;
        endcase
    end

    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i && !packet_ready_i |=> packet_valid_i && $stable(packet_i))
        else $error("packet changed while the encapsulator stalled");

    a_reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !packet_valid_i)
        else $error("packet valid raised during reset");

    a_length: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i |-> packet_i.length == want_len)
        else $error("packet length does not match its format");

endmodule

bind trdb_top trdb_sva trdb_sva_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .packet_valid_i (packet_valid_o),
    .packet_i       (packet_o),
    .packet_ready_i (packet_ready_i)
);

// File: trdb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction trace encoder top, decode to execute to result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "trdb_cfg.svh"

module trdb_top import trdb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  trace_enable_i,
    // retired instructions from the core
    input  logic                  inst_valid_i,
    input  trdb_inst_t            inst_i,
    input  logic [`TRDB_XLEN-1:0] epc_i,
    output logic                  inst_ready_o,
    // packets to the encapsulator
    output logic                  packet_valid_o,
    output trdb_pkt_t             packet_o,
    input  logic                  packet_ready_i
);

    // decode to execute
    logic      dec_valid;
    logic      dec_ready;
    trdb_dec_t dec;
    // execute to result
    logic      pkt_valid;
    logic      pkt_ready;
    trdb_pkt_t pkt;

    trdb_decode i_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .trace_enable_i (trace_enable_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .epc_i          (epc_i),
        .inst_ready_o   (inst_ready_o),
        .dec_valid_o    (dec_valid),
        .dec_o          (dec),
        .dec_ready_i    (dec_ready)
    );

    trdb_execute i_execute (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .trace_enable_i (trace_enable_i),
        .dec_valid_i    (dec_valid),
        .dec_i          (dec),
        .dec_ready_o    (dec_ready),
        .pkt_valid_o    (pkt_valid),
        .pkt_o          (pkt),
        .pkt_ready_i    (pkt_ready)
    );

    trdb_result i_result (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .pkt_valid_i    (pkt_valid),
        .pkt_i          (pkt),
        .pkt_ready_o    (pkt_ready),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o),
        .packet_ready_i (packet_ready_i)
    );

endmodule
